// ==== src/ro_pkg.sv ====
package ro_pkg;

   localparam int N_LANES = 4;
   localparam int LANE_W = 2;
   localparam int WORD_W = 32;
   localparam int LINE_WORDS = 16; // 64-byte cache line
   localparam int WORD_IDX_W = 4;
   localparam int ADDR_W = 32;
   localparam int LEN_W = 8; // up to 255 words per request
   localparam int ID_W = 3;
   localparam int N_IDS = 8;
   localparam int RESP_FIFO_LOG_DEPTH = 2;
   localparam int TAG_W = 8;

   // request from one task lane, addr is word aligned
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [LEN_W-1:0]  n_words;
      logic [TAG_W-1:0]  tag;
   } ro_req_t;

   // what a response needs to find its way back
   typedef struct packed {
      logic [LANE_W-1:0]     lane;
      logic [TAG_W-1:0]      tag;
      logic [LINE_WORDS-1:0] valid_words;
      logic [LEN_W-1:0]      first_word; // request index of lowest valid word
   } ro_mshr_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [ID_W-1:0]   id;
   } ro_rd_req_t;

   typedef struct packed {
      logic [ID_W-1:0]              id;
      logic [LINE_WORDS*WORD_W-1:0] line;
   } ro_rd_resp_t;

   typedef struct packed {
      logic [LANE_W-1:0] lane;
      logic [TAG_W-1:0]  tag;
      logic [LEN_W-1:0]  word_id;
      logic [WORD_W-1:0] data;
   } ro_word_t;

endpackage

// ==== src/ro_lane_arbiter.sv ====
`timescale 1ns/100ps

module ro_lane_arbiter
   import ro_pkg::*;
(
   input  logic [N_LANES-1:0]          lane_valid,
   input  ro_req_t [N_LANES-1:0]       lane_req,
   output logic [N_LANES-1:0]          lane_ready,

   output logic                        grant_valid,
   output logic [LANE_W-1:0]           grant_lane,
   output ro_req_t                     grant_req,
   input  logic                        grant_ready
);

   always_comb begin
      grant_valid = |lane_valid;
      grant_lane = '0;
      // later lanes override earlier ones, so the highest index wins
      for (int i = 0; i < N_LANES; i++) begin
         if (lane_valid[i]) begin
            grant_lane = LANE_W'(i);
         end
      end
      grant_req = lane_req[grant_lane];

      lane_ready = '0;
      if (grant_valid && grant_ready) begin
         lane_ready[grant_lane] = 1'b1;
      end

      // at most one lane accepted, and never one that isn't asking
      assert ($onehot0(lane_ready) && ((lane_ready & ~lane_valid) == '0))
         else $error("lane_ready %b not one-hot on valid lanes %b", lane_ready, lane_valid);
   end

endmodule

// ==== src/ro_burst_splitter.sv ====
`timescale 1ns/100ps

module ro_burst_splitter
   import ro_pkg::*;
(
   input  logic              clk,
   input  logic              rstn,

   input  logic              grant_valid,
   input  logic [LANE_W-1:0] grant_lane,
   input  ro_req_t           grant_req,
   output logic              grant_ready,

   input  logic              id_avail,
   input  logic [ID_W-1:0]   next_id,
   output logic              id_take,

   output logic              ar_valid,
   output ro_rd_req_t        ar,
   input  logic              ar_ready,

   output logic              mshr_we,
   output logic [ID_W-1:0]   mshr_wid,
   output ro_mshr_t          mshr_wdata
);

   logic                  busy; // holding a request with beats left
   logic [ADDR_W-1:0]     cur_addr;
   logic [LEN_W-1:0]      remaining;
   logic [LEN_W-1:0]      first_word;
   logic [LANE_W-1:0]     cur_lane;
   logic [TAG_W-1:0]      cur_tag;

   logic [WORD_IDX_W-1:0] off;
   logic [LEN_W-1:0]      room;       // words left in the current line
   logic [LEN_W-1:0]      beat_words;
   logic                  last_beat;
   logic [LINE_WORDS-1:0] beat_mask;

   assign off = cur_addr[WORD_IDX_W+1:2];
   assign room = LEN_W'(LINE_WORDS) - LEN_W'(off);
   assign last_beat = (remaining <= room);
   assign beat_words = last_beat ? remaining : room;

   always_comb begin
      for (int i = 0; i < LINE_WORDS; i++) begin
         beat_mask[i] = (LEN_W'(i) >= LEN_W'(off)) && (LEN_W'(i) < LEN_W'(off) + beat_words);
      end
   end

   assign ar_valid = busy & id_avail;
   assign ar.addr = cur_addr;
   assign ar.id = next_id;

   assign id_take = ar_valid & ar_ready;

   // miss entry written with the same id the beat carries
   assign mshr_we = id_take;
   assign mshr_wid = next_id;
   assign mshr_wdata.lane = cur_lane;
   assign mshr_wdata.tag = cur_tag;
   assign mshr_wdata.valid_words = beat_mask;
   assign mshr_wdata.first_word = first_word;

   // accept a new request in the cycle the last beat leaves
   assign grant_ready = !busy | (id_take & last_beat);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy <= 1'b0;
      end else if (grant_valid && grant_ready) begin
         busy <= 1'b1;
      end else if (id_take && last_beat) begin
         busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (grant_valid && grant_ready) begin
         cur_addr <= grant_req.addr;
         remaining <= grant_req.n_words;
         first_word <= '0;
         cur_lane <= grant_lane;
         cur_tag <= grant_req.tag;
      end else if (id_take) begin
         cur_addr <= cur_addr + (ADDR_W'(beat_words) << 2); // next line boundary after first beat
         remaining <= remaining - beat_words;
         first_word <= first_word + beat_words;
      end
   end

   a_no_ar_without_id: assert property (@(posedge clk) disable iff (!rstn)
      $rose(ar_valid) |-> id_avail);

   // a stalled beat keeps its address and id until memory takes it
   a_ar_stable: assert property (@(posedge clk) disable iff (!rstn)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar));

endmodule

// ==== src/ro_id_pool.sv ====
`timescale 1ns/100ps

module ro_id_pool
   import ro_pkg::*;
(
   input  logic            clk,
   input  logic            rstn,

   input  logic            take,
   input  logic            give,
   input  logic [ID_W-1:0] give_id,

   output logic            avail,
   output logic [ID_W-1:0] head_id,
   output logic            all_free
);

   logic [ID_W-1:0] ids [N_IDS];
   logic [ID_W-1:0] rd_ptr;
   logic [ID_W-1:0] wr_ptr;
   logic [ID_W:0]   count;

   assign avail = (count != '0);
   assign all_free = (count == (ID_W+1)'(N_IDS));
   assign head_id = ids[rd_ptr];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rd_ptr <= '0;
         wr_ptr <= '0; // full, so write pointer wraps onto read pointer
         count <= (ID_W+1)'(N_IDS);
         for (int i = 0; i < N_IDS; i++) begin
            ids[i] <= ID_W'(i);
         end
      end else begin
         if (take) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (give) begin
            ids[wr_ptr] <= give_id;
            wr_ptr <= wr_ptr + 1'b1;
         end
         case ({take, give})
            2'b10: count <= count - 1'b1;
            2'b01: count <= count + 1'b1;
            default: count <= count;
         endcase
      end
   end

   a_no_take_empty: assert property (@(posedge clk) disable iff (!rstn)
      take |-> avail);

   // an id coming back while all are home means one was freed twice
   a_no_give_full: assert property (@(posedge clk) disable iff (!rstn)
      give |-> !all_free);

endmodule

// ==== src/ro_resp_unpacker.sv ====
`timescale 1ns/100ps

module ro_resp_unpacker
   import ro_pkg::*;
(
   input  logic            clk,
   input  logic            rstn,

   input  logic            mshr_we,
   input  logic [ID_W-1:0] mshr_wid,
   input  ro_mshr_t        mshr_wdata,

   input  logic            r_valid,
   input  ro_rd_resp_t     r,
   output logic            r_ready,

   output logic            out_valid,
   output ro_word_t        out,
   input  logic            out_ready,

   output logic            id_free,
   output logic [ID_W-1:0] id_free_id
);

   localparam int FIFO_DEPTH = 2**RESP_FIFO_LOG_DEPTH;

   ro_mshr_t mshr_table [N_IDS];

   ro_rd_resp_t                    fifo_mem [FIFO_DEPTH];
   logic [RESP_FIFO_LOG_DEPTH-1:0] fifo_rd_ptr;
   logic [RESP_FIFO_LOG_DEPTH-1:0] fifo_wr_ptr;
   logic [RESP_FIFO_LOG_DEPTH:0]   fifo_count;
   logic                           fifo_valid;
   logic                           push;
   logic                           pop;
   ro_rd_resp_t                    fifo_head;

   // unpack register
   logic                         u_valid;
   logic [LINE_WORDS*WORD_W-1:0] u_line;
   ro_mshr_t                     u_mshr;
   logic [LINE_WORDS-1:0]        u_mask; // words not yet sent
   logic [ID_W-1:0]              u_id;
   logic [LEN_W-1:0]             u_word_id;

   logic [WORD_IDX_W-1:0] low_idx;
   logic [LINE_WORDS-1:0] next_mask;
   logic                  word_xfer;
   logic                  last_word;

   always_ff @(posedge clk) begin
      if (mshr_we) begin
         mshr_table[mshr_wid] <= mshr_wdata;
      end
   end

   assign r_ready = (fifo_count != (RESP_FIFO_LOG_DEPTH+1)'(FIFO_DEPTH));
   assign fifo_valid = (fifo_count != '0);
   assign push = r_valid & r_ready;
   assign fifo_head = fifo_mem[fifo_rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         fifo_mem[fifo_wr_ptr] <= r;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         fifo_rd_ptr <= '0;
         fifo_wr_ptr <= '0;
         fifo_count <= '0;
      end else begin
         if (push) fifo_wr_ptr <= fifo_wr_ptr + 1'b1;
         if (pop) fifo_rd_ptr <= fifo_rd_ptr + 1'b1;
         case ({push, pop})
            2'b10: fifo_count <= fifo_count + 1'b1;
            2'b01: fifo_count <= fifo_count - 1'b1;
            default: fifo_count <= fifo_count;
         endcase
      end
   end

   // lowest remaining word goes out first
   always_comb begin
      low_idx = '0;
      for (int i = LINE_WORDS-1; i >= 0; i--) begin
         if (u_mask[i]) low_idx = WORD_IDX_W'(i);
      end
      next_mask = u_mask;
      next_mask[low_idx] = 1'b0;
   end

   assign last_word = (next_mask == '0);
   assign word_xfer = out_valid & out_ready;

   assign out_valid = u_valid;
   assign out.lane = u_mshr.lane;
   assign out.tag = u_mshr.tag;
   assign out.word_id = u_word_id;
   assign out.data = u_line[low_idx*WORD_W +: WORD_W];

   assign id_free = word_xfer & last_word;
   assign id_free_id = u_id;

   assign pop = fifo_valid & (!u_valid | id_free); // reload behind the last word

   always_ff @(posedge clk) begin
      if (!rstn) begin
         u_valid <= 1'b0;
      end else if (pop) begin
         u_valid <= 1'b1;
      end else if (id_free) begin
         u_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (pop) begin
         u_line <= fifo_head.line;
         u_id <= fifo_head.id;
         u_mshr <= mshr_table[fifo_head.id];
         u_mask <= mshr_table[fifo_head.id].valid_words;
         u_word_id <= mshr_table[fifo_head.id].first_word;
      end else if (word_xfer) begin
         u_mask <= next_mask;
         u_word_id <= u_word_id + 1'b1;
      end
   end

   a_mask_nonempty: assert property (@(posedge clk) disable iff (!rstn)
      u_valid |-> (u_mask != '0));

endmodule

// ==== src/ro_stage_top.sv ====
`timescale 1ns/100ps

module ro_stage_top
   import ro_pkg::*;
(
   input  logic                  clk,
   input  logic                  rstn,

   input  logic [N_LANES-1:0]    lane_valid,
   input  ro_req_t [N_LANES-1:0] lane_req,
   output logic [N_LANES-1:0]    lane_ready,

   output logic                  ar_valid,
   output ro_rd_req_t            ar,
   input  logic                  ar_ready,

   input  logic                  r_valid,
   input  ro_rd_resp_t           r,
   output logic                  r_ready,

   output logic                  out_valid,
   output ro_word_t              out,
   input  logic                  out_ready,

   output logic                  idle
);

   logic              grant_valid;
   logic [LANE_W-1:0] grant_lane;
   ro_req_t           grant_req;
   logic              grant_ready;

   logic              id_avail;
   logic [ID_W-1:0]   next_id;
   logic              id_take;
   logic              id_free;
   logic [ID_W-1:0]   id_free_id;

   logic              mshr_we;
   logic [ID_W-1:0]   mshr_wid;
   ro_mshr_t          mshr_wdata;

   ro_lane_arbiter i_arb (
      .lane_valid  (lane_valid),
      .lane_req    (lane_req),
      .lane_ready  (lane_ready),
      .grant_valid (grant_valid),
      .grant_lane  (grant_lane),
      .grant_req   (grant_req),
      .grant_ready (grant_ready)
   );

   ro_burst_splitter i_split (
      .clk         (clk),
      .rstn        (rstn),
      .grant_valid (grant_valid),
      .grant_lane  (grant_lane),
      .grant_req   (grant_req),
      .grant_ready (grant_ready),
      .id_avail    (id_avail),
      .next_id     (next_id),
      .id_take     (id_take),
      .ar_valid    (ar_valid),
      .ar          (ar),
      .ar_ready    (ar_ready),
      .mshr_we     (mshr_we),
      .mshr_wid    (mshr_wid),
      .mshr_wdata  (mshr_wdata)
   );

   ro_id_pool i_pool (
      .clk      (clk),
      .rstn     (rstn),
      .take     (id_take),
      .give     (id_free),
      .give_id  (id_free_id),
      .avail    (id_avail),
      .head_id  (next_id),
      .all_free (idle) // every read id home
   );

   ro_resp_unpacker i_unpack (
      .clk        (clk),
      .rstn       (rstn),
      .mshr_we    (mshr_we),
      .mshr_wid   (mshr_wid),
      .mshr_wdata (mshr_wdata),
      .r_valid    (r_valid),
      .r          (r),
      .r_ready    (r_ready),
      .out_valid  (out_valid),
      .out        (out),
      .out_ready  (out_ready),
      .id_free    (id_free),
      .id_free_id (id_free_id)
   );

endmodule

// ==== test/tb_mem_model.sv ====
`timescale 1ns/100ps

module tb_mem_model
   import ro_pkg::*;
(
   input  logic        clk,
   input  logic        rstn,
   input  logic        hold,     // keep every response back
   input  logic        stall_en, // random arready stalls and response gaps
   input  logic        ar_valid,
   input  ro_rd_req_t  ar,
   output logic        ar_ready,
   output logic        r_valid,
   output ro_rd_resp_t r,
   input  logic        r_ready
);

   ro_rd_req_t pend [$]; // accepted beats without a response yet

   // whole 64-byte line, each word is its byte address scrambled
   function automatic ro_rd_resp_t make_resp(ro_rd_req_t req);
      ro_rd_resp_t       resp;
      logic [ADDR_W-1:0] base;
      base = {req.addr[ADDR_W-1:6], 6'b0};
      resp.id = req.id;
      for (int i = 0; i < LINE_WORDS; i++) begin
         resp.line[i*WORD_W +: WORD_W] = (base + ADDR_W'(4 * i)) ^ 32'hA5A5_0000;
      end
      return resp;
   endfunction

   initial begin
      ar_ready <= 1'b0;
      r_valid <= 1'b0;
      r <= '0;
   end

   always @(posedge clk) begin
      if (!rstn) begin
         ar_ready <= 1'b0;
         r_valid <= 1'b0;
         pend.delete();
      end else begin
         if (ar_valid && ar_ready) pend.push_back(ar);
         ar_ready <= !stall_en || ($urandom % 4 != 0);
         // newest beat answered first, so held beats come back reversed
         if (!r_valid || r_ready) begin
            if (!hold && pend.size() != 0 && (!stall_en || $urandom % 3 != 0)) begin
               r <= make_resp(pend.pop_back());
               r_valid <= 1'b1;
            end else begin
               r_valid <= 1'b0;
            end
         end
      end
   end

endmodule

// ==== test/tb_ro_stage.sv ====
`timescale 1ns/100ps

module tb_ro_stage
   import ro_pkg::*;
();

   localparam int TIMEOUT_CYCLES = 4000; // roughly 1200 cycles of tests plus margin
   localparam logic [WORD_W-1:0] DATA_KEY = 32'hA5A5_0000;

   logic                  clk = 1'b0;
   logic                  rstn;
   logic [N_LANES-1:0]    lane_valid;
   ro_req_t [N_LANES-1:0] lane_req;
   logic [N_LANES-1:0]    lane_ready;
   logic                  ar_valid;
   ro_rd_req_t            ar;
   logic                  ar_ready;
   logic                  r_valid;
   ro_rd_resp_t           r;
   logic                  r_ready;
   logic                  out_valid;
   ro_word_t              out;
   logic                  out_ready;
   logic                  idle;
   logic                  hold;
   logic                  stall_en;
   logic                  rand_ready = 1'b0; // toggle out_ready at random

   int                errors = 0;
   int                checks = 0;
   int                cycles = 0;
   ro_rd_req_t        ar_q [$];  // beats seen on the read channel
   ro_word_t          out_q [$]; // words seen on the output
   logic [LANE_W-1:0] grant_q [$];
   logic [ADDR_W-1:0] req_addr [256]; // expected requests, by tag
   logic [LEN_W-1:0]  req_n [256];
   logic [LANE_W-1:0] req_lane [256];
   bit                req_known [256];

   ro_stage_top i_dut (.*);
   tb_mem_model i_mem (.*);

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   function automatic logic [WORD_W-1:0] word_data(logic [TAG_W-1:0] tag, int k);
      return (req_addr[tag] + ADDR_W'(4 * k)) ^ DATA_KEY;
   endfunction

   function automatic int line_of(logic [TAG_W-1:0] tag, int k);
      return int'((req_addr[tag] + ADDR_W'(4 * k)) >> 6);
   endfunction

   // request index of the first requested word in the line that holds word k
   function automatic int line_start(logic [TAG_W-1:0] tag, int k);
      int start;
      start = k - ((int'(req_addr[tag][5:2]) + k) % LINE_WORDS);
      return (start < 0) ? 0 : start;
   endfunction

   task automatic note_failure(string what);
      errors++;
      $display("%s", what);
   endtask

   // fields shown as lane/tag/word_id/data
   task automatic check_word(string name, ro_word_t exp, ro_word_t got);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t: %s expected %0d/%h/%0d/%h got %0d/%h/%0d/%h", $time, name,
            exp.lane, exp.tag, exp.word_id, exp.data, got.lane, got.tag, got.word_id, got.data);
      end
   endtask

   task automatic check_rd_req(string name, ro_rd_req_t exp, ro_rd_req_t got);
      checks++;
      if (got.addr !== exp.addr) begin
         errors++;
         $display("error at %0t: %s.addr expected %h got %h", $time, name, exp.addr, got.addr);
      end
   endtask

   task automatic check_bit(string name, logic exp, logic got);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t: %s expected %b got %b", $time, name, exp, got);
      end
   endtask

   // values read right after the edge are the ones it sampled
   task automatic step();
      @(posedge clk);
      if (ar_valid && ar_ready) ar_q.push_back(ar);
      if (out_valid && out_ready) out_q.push_back(out);
      for (int i = 0; i < N_LANES; i++) begin
         if (lane_valid[i] && lane_ready[i]) begin
            grant_q.push_back(LANE_W'(i));
            lane_valid[i] <= 1'b0;
         end
      end
      out_ready <= rand_ready ? 1'($urandom) : 1'b1;
   endtask

   task automatic post_req(logic [LANE_W-1:0] lane, logic [ADDR_W-1:0] addr,
                           logic [LEN_W-1:0] n, logic [TAG_W-1:0] tag);
      ro_req_t req;
      req.addr = addr;
      req.n_words = n;
      req.tag = tag;
      lane_req[lane] <= req;
      lane_valid[lane] <= 1'b1;
      req_addr[tag] = addr;
      req_n[tag] = n;
      req_lane[tag] = lane;
      req_known[tag] = 1'b1;
   endtask

   task automatic wait_words(int n);
      while (out_q.size() < n) step();
   endtask

   task automatic wait_idle();
      step();
      while (!idle) step();
   endtask

   task automatic check_beats(logic [TAG_W-1:0] tag);
      ro_rd_req_t exp;
      int         left;
      int         w;
      exp = '0;
      exp.addr = req_addr[tag];
      left = int'(req_n[tag]);
      while (left > 0) begin
         w = LINE_WORDS - int'(exp.addr[5:2]); // rest of the line
         if (w > left) w = left;
         if (ar_q.size() == 0) begin
            note_failure($sformatf("beat at %h for tag %h was never issued", exp.addr, tag));
            return;
         end
         check_rd_req("ar", exp, ar_q.pop_front());
         exp.addr = exp.addr + ADDR_W'(4 * w);
         left = left - w;
      end
   endtask

   task automatic check_in_order(logic [TAG_W-1:0] tag);
      ro_word_t exp;
      for (int k = 0; k < int'(req_n[tag]); k++) begin
         if (out_q.size() == 0) begin
            note_failure($sformatf("tag %h word %0d never came out", tag, k));
            return;
         end
         exp.lane = req_lane[tag];
         exp.tag = tag;
         exp.word_id = LEN_W'(k);
         exp.data = word_data(tag, k);
         check_word("out", exp, out_q.pop_front());
      end
   endtask

   // every word once and ascending inside each response
   task automatic check_any_order(int total);
      ro_word_t got;
      ro_word_t exp;
      ro_word_t prev;
      bit       have_prev;
      bit       seen [int];
      int       key;
      have_prev = 1'b0;
      if (out_q.size() != total) begin
         note_failure($sformatf("expected %0d output words, saw %0d", total, out_q.size()));
      end
      while (out_q.size() != 0) begin
         got = out_q.pop_front();
         key = int'({got.tag, got.word_id});
         if (!req_known[got.tag]) begin
            note_failure($sformatf("output word carries unknown tag %h", got.tag));
         end else begin
            exp.lane = req_lane[got.tag];
            exp.tag = got.tag;
            if (have_prev && prev.tag == got.tag
                && line_of(got.tag, int'(prev.word_id)) == line_of(got.tag, int'(got.word_id)))
               exp.word_id = prev.word_id + 1'b1; // same response
            else
               exp.word_id = LEN_W'(line_start(got.tag, int'(got.word_id)));
            exp.data = word_data(got.tag, int'(exp.word_id));
            check_word("out", exp, got);
            if (got.word_id >= req_n[got.tag])
               note_failure($sformatf("tag %h word %0d is past the request", got.tag, got.word_id));
            else if (seen.exists(key))
               note_failure($sformatf("tag %h word %0d came out twice", got.tag, got.word_id));
            seen[key] = 1'b1;
         end
         prev = got;
         have_prev = 1'b1;
      end
   endtask

   task automatic check_drained();
      if (ar_q.size() != 0 || out_q.size() != 0) begin
         note_failure($sformatf("%0d extra beats and %0d extra words", ar_q.size(), out_q.size()));
      end
      ar_q.delete();
      out_q.delete();
      grant_q.delete();
   endtask

   task automatic test_single_line();
      step();
      post_req(2'd1, 32'h0000_1008, 8'd5, 8'h11);
      wait_words(5);
      step();
      check_bit("idle", 1'b1, idle); // last id home right after the last word
      check_beats(8'h11);
      check_in_order(8'h11);
      check_drained();
   endtask

   task automatic test_three_lines();
      step();
      post_req(2'd0, 32'h0000_2028, 8'd28, 8'h22); // offset 10 gives beats of 6, 16 and 6
      wait_words(28);
      wait_idle();
      check_beats(8'h22);
      check_in_order(8'h22);
      check_drained();
   endtask

   task automatic test_priority();
      logic [LANE_W-1:0] order [3] = '{2'd3, 2'd2, 2'd0};
      step();
      post_req(2'd0, 32'h0000_5000, 8'd3, 8'h30);
      post_req(2'd2, 32'h0000_5100, 8'd3, 8'h32);
      post_req(2'd3, 32'h0000_5200, 8'd3, 8'h33);
      wait_words(9);
      wait_idle();
      foreach (order[i]) begin
         if (grant_q.size() <= i || grant_q[i] != order[i])
            note_failure($sformatf("grant %0d did not go to lane %0d", i, order[i]));
      end
      check_beats(8'h33);
      check_beats(8'h32);
      check_beats(8'h30);
      check_in_order(8'h33);
      check_in_order(8'h32);
      check_in_order(8'h30);
      check_drained();
   endtask

   task automatic test_backpressure();
      rand_ready = 1'b1;
      stall_en <= 1'b1;
      step();
      post_req(2'd0, 32'h0000_3004, 8'd40, 8'h40);
      post_req(2'd1, 32'h0000_3404, 8'd17, 8'h41);
      post_req(2'd2, 32'h0000_3800, 8'd16, 8'h42);
      post_req(2'd3, 32'h0000_3c3c, 8'd3, 8'h43);
      wait_words(76);
      wait_idle();
      check_beats(8'h43);
      check_beats(8'h42);
      check_beats(8'h41);
      check_beats(8'h40);
      check_any_order(76);
      check_drained();
   endtask

   task automatic test_id_exhaustion();
      hold <= 1'b1;
      step();
      post_req(2'd1, 32'h0000_8000, 8'd200, 8'h55); // 13 lines
      while (ar_q.size() < N_IDS) step();
      repeat (20) step();
      if (ar_q.size() != N_IDS)
         note_failure($sformatf("%0d beats issued with all responses held", ar_q.size()));
      check_bit("ar_valid", 1'b0, ar_valid);
      hold <= 1'b0;
      wait_words(200);
      step();
      check_bit("idle", 1'b1, idle);
      check_beats(8'h55);
      check_any_order(200);
      check_drained();
   endtask

   initial begin
      void'($urandom(32'he5f7));
      rstn <= 1'b0;
      lane_valid <= '0;
      lane_req <= '0;
      out_ready <= 1'b1;
      hold <= 1'b0;
      stall_en <= 1'b0;
      repeat (4) @(posedge clk);
      rstn <= 1'b1;
      step();
      check_bit("ar_valid", 1'b0, ar_valid);
      check_bit("out_valid", 1'b0, out_valid);
      check_bit("lane_ready", 1'b0, |lane_ready);
      check_bit("r_ready", 1'b1, r_ready);
      check_bit("idle", 1'b1, idle);

      test_single_line();
      test_three_lines();
      test_priority();
      test_backpressure();
      test_id_exhaustion();

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== project.f ====
src/ro_pkg.sv
src/ro_lane_arbiter.sv
src/ro_burst_splitter.sv
src/ro_id_pool.sv
src/ro_resp_unpacker.sv
src/ro_stage_top.sv
test/tb_mem_model.sv
test/tb_ro_stage.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, verdict taken from sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ro_stage \
   -f project.f -o tb_ro_stage

./obj_dir/tb_ro_stage > sim.log 2>&1 || true
cat sim.log

grep -q "TESTBENCH PASSED" sim.log
